//--- src.f
+incdir+hdl
hdl/remap_pkg.sv
hdl/remap_if.sv
hdl/region_table.sv
hdl/range_matcher.sv
hdl/wait_timer.sv
hdl/req_fsm.sv
hdl/remap_top.sv
bench/remap_checker.sv
bench/remap_tb.sv

//--- Makefile
# Verilator simulation of the remap unit

sim:
	verilator --binary --timing --top-module remap_tb -f src.f -o remap_sim
	out=$$(./obj_dir/remap_sim); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bench/remap_tb.sv
/* Testbench of the remap unit. Programs four disjoint regions, drives single
   requests and answers downstream through a simple responder model */
`timescale 1ns/1ps
`include "remap_macros.svh"

module remap_tb;

	// Longest wait for idle or a response
	localparam int WAIT_LIMIT = `REMAP_TIMEOUT + 40;

	logic clk;
	logic rst_n;
	logic cfg_we;
	logic [`REMAP_IDXW-1:0] cfg_idx;
	remap_pkg::cfg_field_e cfg_field;
	logic [`REMAP_AW-1:0] cfg_wdata;
	logic req_valid;
	logic [`REMAP_AW-1:0] req_addr;
	logic req_write;
	logic [`REMAP_AW-1:0] req_wdata;
	logic busy;
	logic dn_req;
	logic [`REMAP_AW-1:0] dn_addr;
	logic dn_write;
	logic [`REMAP_AW-1:0] dn_wdata;
	logic dn_ack = 1'b0;
	logic [`REMAP_AW-1:0] dn_rdata = '0;
	logic rsp_valid;
	remap_pkg::rsp_code_e rsp_code;
	logic [`REMAP_AW-1:0] rsp_rdata;
	logic [`REMAP_IDXW-1:0] rsp_region;

	integer seed = 32'hf4f82415;
	int chk_errors;
	int chk_checks;
	int chk_responses;
	int tb_errors = 0;
	int sent = 0;

	// Responder state, stall_req withholds the acknowledge
	logic stall_req = 1'b0;
	logic ack_wait = 1'b0;
	int ack_cnt = 0;
	logic [`REMAP_AW-1:0] ack_addr = '0;

	// Region layout chosen by the stimulus
	logic [`REMAP_AW-1:0] region_base [`REMAP_NREG];
	logic [`REMAP_AW-1:0] region_last [`REMAP_NREG];

	remap_top UUT
	(
		.clk(clk), .rst_n(rst_n),
		.cfg_we(cfg_we), .cfg_idx(cfg_idx), .cfg_field(cfg_field), .cfg_wdata(cfg_wdata),
		.req_valid(req_valid), .req_addr(req_addr), .req_write(req_write),
		.req_wdata(req_wdata), .busy(busy),
		.dn_req(dn_req), .dn_addr(dn_addr), .dn_write(dn_write), .dn_wdata(dn_wdata),
		.dn_ack(dn_ack), .dn_rdata(dn_rdata),
		.rsp_valid(rsp_valid), .rsp_code(rsp_code), .rsp_rdata(rsp_rdata),
		.rsp_region(rsp_region)
	);

	remap_checker chk
	(
		.clk(clk), .rst_n(rst_n),
		.cfg_we(cfg_we), .cfg_idx(cfg_idx), .cfg_field(cfg_field), .cfg_wdata(cfg_wdata),
		.req_valid(req_valid), .req_addr(req_addr), .req_write(req_write),
		.req_wdata(req_wdata), .busy(busy),
		.dn_req(dn_req), .dn_addr(dn_addr), .dn_write(dn_write), .dn_wdata(dn_wdata),
		.dn_ack(dn_ack), .rsp_valid(rsp_valid), .rsp_code(rsp_code),
		.rsp_rdata(rsp_rdata), .rsp_region(rsp_region),
		.errors(chk_errors), .checks(chk_checks), .responses(chk_responses)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ****************************************
	// Downstream responder
	// ****************************************

	// Acks 1 to 11 cycles after dn_req with the inverted address as data
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dn_ack <= 1'b0;
			ack_wait <= 1'b0;
		end
		else
		begin
			dn_ack <= 1'b0;
			if (ack_wait)
			begin
				if (ack_cnt == 0)
				begin
					dn_ack <= 1'b1;
					dn_rdata <= ~ack_addr;
					ack_wait <= 1'b0;
				end
				else
				begin
					ack_cnt <= ack_cnt - 1;
				end
			end
			else if (dn_req && !stall_req)
			begin
				ack_wait <= 1'b1;
				ack_cnt <= int'($unsigned($random(seed)) % 11);
				ack_addr <= dn_addr;
			end
		end
	end

	// ****************************************
	// Run control
	// ****************************************

	task automatic finish_run();
		$display("checks %0d, responses %0d of %0d, checker errors %0d, bench errors %0d",
			chk_checks, chk_responses, sent, chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	task automatic give_up(input string msg);
		tb_errors++;
		$display("Timeout at %0t ns: %s", $time, msg);
		finish_run();
	endtask

	task automatic cfg_write(input int idx, input remap_pkg::cfg_field_e field,
		input logic [`REMAP_AW-1:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_idx <= `REMAP_IDXW'(idx);
		cfg_field <= field;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge clk);
		while (busy && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (busy)
			give_up("DUT stayed busy before a new request");
	endtask

	// One request, then wait for its response
	// poke adds a req_valid pulse while the request is in flight
	task automatic send_req(input logic [`REMAP_AW-1:0] addr, input logic write,
		input logic [`REMAP_AW-1:0] wdata, input logic stall, input logic poke);
		int n;
		wait_idle();
		stall_req <= stall;
		req_valid <= 1'b1;
		req_addr <= addr;
		req_write <= write;
		req_wdata <= wdata;
		@(posedge clk);
		req_valid <= 1'b0;
		sent++;
		if (poke)
		begin
			@(posedge clk);
			req_valid <= 1'b1;
			req_addr <= ~addr;
			@(posedge clk);
			req_valid <= 1'b0;
		end
		n = 0;
		while (!rsp_valid && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (!rsp_valid)
			give_up("no response to a request");
	endtask

	// ****************************************
	// Stimulus
	// ****************************************

	initial
	begin
		logic [`REMAP_AW-1:0] a;
		logic [`REMAP_AW-1:0] rnd;
		int r;

		rst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_idx = '0;
		cfg_field = remap_pkg::BASE;
		cfg_wdata = '0;
		req_valid = 1'b0;
		req_addr = '0;
		req_write = 1'b0;
		req_wdata = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// Empty table, every request decodes as an error
		for (int k = 0; k < 4; k++)
		begin
			rnd = $random(seed);
			send_req($random(seed), rnd[0], $random(seed), 1'b0, 1'b0);
		end

		// Four disjoint 16 KB regions with random offsets
		for (int i = 0; i < `REMAP_NREG; i++)
		begin
			region_base[i] = 32'(i + 1) << 28;
			region_last[i] = region_base[i] + 32'h3F80;
			cfg_write(i, remap_pkg::BASE, region_base[i]);
			cfg_write(i, remap_pkg::LAST, region_last[i]);
			cfg_write(i, remap_pkg::OFFSET, $random(seed));
			cfg_write(i, remap_pkg::CTRL, 32'h1);
		end

		// Random hits inside the regions
		for (int k = 0; k < 24; k++)
		begin
			r = int'($unsigned($random(seed)) % `REMAP_NREG);
			a = region_base[r] + ($unsigned($random(seed)) % 32'h4000);
			rnd = $random(seed);
			send_req(a, rnd[0], $random(seed), 1'b0, 1'b0);
		end

		// Granule edges, inside and one granule outside
		for (int i = 0; i < `REMAP_NREG; i++)
		begin
			send_req(region_base[i], 1'b0, '0, 1'b0, 1'b0);
			send_req(region_last[i] | 32'h7F, 1'b1, $random(seed), 1'b0, 1'b0);
			send_req(region_base[i] - 32'h80, 1'b0, '0, 1'b0, 1'b0);
			send_req(region_last[i] + 32'h80, 1'b0, '0, 1'b0, 1'b0);
		end

		// Disable region 2, reserved control bits set
		cfg_write(2, remap_pkg::CTRL, 32'hFFFF_FFFE);
		send_req(region_base[2] + 32'h100, 1'b0, '0, 1'b0, 1'b0);
		send_req(region_last[2], 1'b1, $random(seed), 1'b0, 1'b0);
		cfg_write(2, remap_pkg::CTRL, 32'h1);
		send_req(region_base[2] + 32'h100, 1'b0, '0, 1'b0, 1'b0);

		// Withheld acknowledge, then a request poked while busy
		send_req(region_base[1] + 32'h40, 1'b0, '0, 1'b1, 1'b0);
		send_req(region_base[3] + 32'h200, 1'b1, $random(seed), 1'b0, 1'b1);
		send_req(region_base[0] + 32'h80, 1'b0, '0, 1'b0, 1'b0);

		// Let the checker see the last response
		repeat (4) @(posedge clk);
		if (chk_responses != sent)
		begin
			tb_errors++;
			$display("Response count %0d does not match %0d requests sent",
				chk_responses, sent);
		end
		finish_run();
	end

endmodule

//--- bench/remap_checker.sv
/* Response checker for the remap unit. Follows one request at a time, as the DUT
   does, and keeps its own copy of the region table from the configuration strobes */
`timescale 1ns/1ps
`include "remap_macros.svh"

module remap_checker
(
	input logic clk,
	input logic rst_n,
	input logic cfg_we,
	input logic [`REMAP_IDXW-1:0] cfg_idx,
	input remap_pkg::cfg_field_e cfg_field,
	input logic [`REMAP_AW-1:0] cfg_wdata,
	input logic req_valid,
	input logic [`REMAP_AW-1:0] req_addr,
	input logic req_write,
	input logic [`REMAP_AW-1:0] req_wdata,
	input logic busy,
	input logic dn_req,
	input logic [`REMAP_AW-1:0] dn_addr,
	input logic dn_write,
	input logic [`REMAP_AW-1:0] dn_wdata,
	input logic dn_ack,
	input logic rsp_valid,
	input remap_pkg::rsp_code_e rsp_code,
	input logic [`REMAP_AW-1:0] rsp_rdata,
	input logic [`REMAP_IDXW-1:0] rsp_region,
	output int errors,
	output int checks,
	output int responses
);

	// Cycles after acceptance before a response counts as lost
	localparam int LOST_LIMIT = `REMAP_TIMEOUT + 16;

	// Expected lookup result
	typedef struct packed
	{
		logic hit;
		logic [`REMAP_IDXW-1:0] idx;
		logic [`REMAP_AW-1:0] xlat;
	} ref_t;

	// ****************************************
	// Table copy and reference
	// ****************************************

	logic [`REMAP_AW-1:0] base_copy [`REMAP_NREG];
	logic [`REMAP_AW-1:0] last_copy [`REMAP_NREG];
	logic [`REMAP_AW-1:0] offset_copy [`REMAP_NREG];
	logic [`REMAP_NREG-1:0] en_copy;

	// Request in flight
	logic pending;
	ref_t exp_r;
	logic exp_write;
	logic [`REMAP_AW-1:0] exp_wdata;
	int age;
	int wait_cnt;
	logic dn_seen;
	logic ack_seen;

	// First enabled region whose granule range holds the address
	function automatic ref_t ref_remap(input logic [`REMAP_AW-1:0] addr);
		ref_t r;
		r = '0;
		for (int i = 0; i < `REMAP_NREG; i++)
		begin
			if (!r.hit && en_copy[i]
				&& ((addr >> `REMAP_GRAN_BITS) >= (base_copy[i] >> `REMAP_GRAN_BITS))
				&& ((addr >> `REMAP_GRAN_BITS) <= (last_copy[i] >> `REMAP_GRAN_BITS)))
			begin
				r.hit = 1'b1;
				r.idx = `REMAP_IDXW'(i);
				// Wraps at 2^32 by width
				r.xlat = addr + offset_copy[i];
			end
		end
		return r;
	endfunction

	task automatic compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// ****************************************
	// Response check
	// ****************************************

	task automatic check_response();
		if (!exp_r.hit)
		begin
			compare_word("decode error latency", 32'(age), 32'd2);
			compare_word("rsp_code", 32'(rsp_code), 32'(remap_pkg::DECODE_ERR));
		end
		else if (!dn_seen)
		begin
			note_error("response to a hit arrived before any dn_req");
		end
		else if (ack_seen)
		begin
			compare_word("rsp_code", 32'(rsp_code), 32'(remap_pkg::OK));
			// Responder returns the inverted translated address
			compare_word("rsp_rdata", rsp_rdata, ~exp_r.xlat);
			compare_word("rsp_region", 32'(rsp_region), 32'(exp_r.idx));
		end
		else
		begin
			compare_word("rsp_code", 32'(rsp_code), 32'(remap_pkg::TIMEOUT_ERR));
			compare_word("rsp_rdata", rsp_rdata, 32'h0);
			// Limit counts from the end of the dn_req pulse, one edge after it was seen
			compare_word("timeout latency", 32'(wait_cnt), 32'(`REMAP_TIMEOUT + 1));
		end
		responses++;
		pending = 1'b0;
	endtask

	// Samples on the rising edge, before the DUT registers update
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			errors = 0;
			checks = 0;
			responses = 0;
			pending = 1'b0;
			exp_r = '0;
			exp_write = 1'b0;
			exp_wdata = '0;
			age = 0;
			wait_cnt = 0;
			dn_seen = 1'b0;
			ack_seen = 1'b0;
			en_copy = '0;
			for (int i = 0; i < `REMAP_NREG; i++)
			begin
				base_copy[i] = '0;
				last_copy[i] = '0;
				offset_copy[i] = '0;
			end
		end
		else
		begin
			// Table copy follows every configuration strobe
			if (cfg_we)
			begin
				case (cfg_field)
					remap_pkg::BASE: base_copy[cfg_idx] = cfg_wdata;
					remap_pkg::LAST: last_copy[cfg_idx] = cfg_wdata;
					remap_pkg::OFFSET: offset_copy[cfg_idx] = cfg_wdata;
					remap_pkg::CTRL: en_copy[cfg_idx] = cfg_wdata[0];
				endcase
			end

			if (pending)
			begin
				age++;
				if (dn_seen)
				begin
					wait_cnt++;
				end
				if (dn_req)
				begin
					if (!exp_r.hit || dn_seen || age != 2)
					begin
						note_error("unexpected dn_req for the pending request");
					end
					else
					begin
						compare_word("dn_addr", dn_addr, exp_r.xlat);
						compare_word("dn_write", 32'(dn_write), 32'(exp_write));
						compare_word("dn_wdata", dn_wdata, exp_wdata);
						dn_seen = 1'b1;
						wait_cnt = 0;
					end
				end
				if (rsp_valid)
				begin
					check_response();
				end
				else if (dn_seen && dn_ack)
				begin
					ack_seen = 1'b1;
				end
				// Hit or miss is decided two cycles after acceptance
				if (pending && age == 2 && !dn_seen)
				begin
					note_error("no dn_req or response two cycles after acceptance");
					pending = 1'b0;
				end
				if (pending && age > LOST_LIMIT)
				begin
					note_error("response lost, nothing came back for the request");
					pending = 1'b0;
				end
			end
			else if (dn_req || rsp_valid)
			begin
				note_error("dn_req or rsp_valid without an accepted request");
			end

			// Busy mirrors the checker's own view of a request in flight
			compare_word("busy", 32'(busy), 32'(pending));

			if (req_valid && !pending)
			begin
				pending = 1'b1;
				exp_r = ref_remap(req_addr);
				exp_write = req_write;
				exp_wdata = req_wdata;
				age = 0;
				wait_cnt = 0;
				dn_seen = 1'b0;
				ack_seen = 1'b0;
			end
		end
	end

endmodule

//--- hdl/remap_top.sv
/* Address remap unit, four regions with a 128 byte granule. No bursts and no table
   read-back, and requests arriving while busy are dropped */
`timescale 1ns/1ps
`include "remap_macros.svh"

module remap_top
(
	input logic clk,
	input logic rst_n,
	// Table programming
	input logic cfg_we,
	input logic [`REMAP_IDXW-1:0] cfg_idx,
	input remap_pkg::cfg_field_e cfg_field,
	input logic [`REMAP_AW-1:0] cfg_wdata,
	// Request side
	input logic req_valid,
	input logic [`REMAP_AW-1:0] req_addr,
	input logic req_write,
	input logic [`REMAP_AW-1:0] req_wdata,
	output logic busy,
	// Downstream memory port
	output logic dn_req,
	output logic [`REMAP_AW-1:0] dn_addr,
	output logic dn_write,
	output logic [`REMAP_AW-1:0] dn_wdata,
	input logic dn_ack,
	input logic [`REMAP_AW-1:0] dn_rdata,
	// Response
	output logic rsp_valid,
	output remap_pkg::rsp_code_e rsp_code,
	output logic [`REMAP_AW-1:0] rsp_rdata,
	output logic [`REMAP_IDXW-1:0] rsp_region
);

	// ****************************************
	// Internal connections
	// ****************************************

	table_if tbl_if ();
	lookup_if lkp_if ();

	// Timer handshake
	logic tmr_start;
	logic tmr_stop;
	logic tmr_expired;

	region_table u_region_table
	(
		.clk(clk),
		.rst_n(rst_n),
		.cfg_we(cfg_we),
		.cfg_idx(cfg_idx),
		.cfg_field(cfg_field),
		.cfg_wdata(cfg_wdata),
		.tbl(tbl_if.owner)
	);

	range_matcher u_range_matcher
	(
		.tbl(tbl_if.user),
		.lkp(lkp_if.matcher)
	);

	wait_timer u_wait_timer
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(tmr_start),
		.stop(tmr_stop),
		.expired(tmr_expired)
	);

	req_fsm u_req_fsm
	(
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.busy(busy),
		.dn_req(dn_req),
		.dn_addr(dn_addr),
		.dn_write(dn_write),
		.dn_wdata(dn_wdata),
		.dn_ack(dn_ack),
		.dn_rdata(dn_rdata),
		.rsp_valid(rsp_valid),
		.rsp_code(rsp_code),
		.rsp_rdata(rsp_rdata),
		.rsp_region(rsp_region),
		.tmr_start(tmr_start),
		.tmr_stop(tmr_stop),
		.tmr_expired(tmr_expired),
		.lkp(lkp_if.requester)
	);

endmodule

//--- hdl/req_fsm.sv
/* Request sequencer with one request in flight. req_valid is ignored while busy,
   and dn_ack is only looked at in the wait state */
`timescale 1ns/1ps
`include "remap_macros.svh"

module req_fsm
(
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic [`REMAP_AW-1:0] req_addr,
	input logic req_write,
	input logic [`REMAP_AW-1:0] req_wdata,
	output logic busy,
	output logic dn_req,
	output logic [`REMAP_AW-1:0] dn_addr,
	output logic dn_write,
	output logic [`REMAP_AW-1:0] dn_wdata,
	input logic dn_ack,
	input logic [`REMAP_AW-1:0] dn_rdata,
	output logic rsp_valid,
	output remap_pkg::rsp_code_e rsp_code,
	output logic [`REMAP_AW-1:0] rsp_rdata,
	output logic [`REMAP_IDXW-1:0] rsp_region,
	output logic tmr_start,
	output logic tmr_stop,
	input logic tmr_expired,
	lookup_if.requester lkp
);

	typedef enum logic [1:0]
	{
		IDLE   = 2'd0,
		LOOKUP = 2'd1,
		WAIT   = 2'd2
	} state_t;

	state_t state;

	// Latched request
	logic [`REMAP_AW-1:0] addr_q;
	logic write_q;
	logic [`REMAP_AW-1:0] wdata_q;

	logic accept;
	logic wait_done;

	assign accept = (state == IDLE) && req_valid;
	// Ack has priority over a timeout in the same cycle
	assign wait_done = (state == WAIT) && (dn_ack || tmr_expired);

	assign busy = (state != IDLE);
	assign lkp.addr = addr_q;

	// Write info stays stable for the whole downstream access
	assign dn_write = write_q;
	assign dn_wdata = wdata_q;

	// Timer spans the dn_req pulse and the wait state
	assign tmr_start = (state == LOOKUP) && lkp.hit;
	assign tmr_stop = wait_done;

	// ****************************************
	// Control state
	// ****************************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			dn_req    <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			// Both strobes are single cycle
			dn_req    <= 1'b0;
			rsp_valid <= 1'b0;
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						state <= LOOKUP;
					end
				end
				LOOKUP:
				begin
					if (lkp.hit)
					begin
						dn_req <= 1'b1;
						state  <= WAIT;
					end
					else
					begin
						// Miss answers at once
						rsp_valid <= 1'b1;
						state     <= IDLE;
					end
				end
				WAIT:
				begin
					if (wait_done)
					begin
						rsp_valid <= 1'b1;
						state     <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ****************************************
	// Payload
	// ****************************************

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q  <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
		end
		if (state == LOOKUP)
		begin
			dn_addr    <= lkp.xlat_addr;
			rsp_region <= lkp.hit_idx;
			// Code and data only matter on a miss here
			rsp_code   <= remap_pkg::DECODE_ERR;
			rsp_rdata  <= '0;
		end
		else if (state == WAIT)
		begin
			if (dn_ack)
			begin
				rsp_code  <= remap_pkg::OK;
				rsp_rdata <= dn_rdata;
			end
			else if (tmr_expired)
			begin
				rsp_code  <= remap_pkg::TIMEOUT_ERR;
				rsp_rdata <= '0;
			end
		end
	end

	// Downstream issue and response are exclusive steps of one request
	a_req_rsp_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(dn_req && rsp_valid)
	) else $error("dn_req and rsp_valid high together");

	// One response per accepted request, never back to back
	a_rsp_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp_valid |=> !rsp_valid
	) else $error("rsp_valid high in two consecutive cycles");

endmodule

//--- hdl/wait_timer.sv
/* Acknowledge wait counter. expired pulses once, REMAP_TIMEOUT cycles after the
   start cycle, unless stop arrives first */
`timescale 1ns/1ps
`include "remap_macros.svh"

module wait_timer
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic stop,
	output logic expired
);

	// Wide enough to hold the limit itself
	localparam int CW = $clog2(`REMAP_TIMEOUT + 1);

	logic [CW-1:0] count;
	logic running;
	logic at_limit;

	assign at_limit = (count == CW'(`REMAP_TIMEOUT));

	// Start wins over stop and restarts from zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count   <= '0;
			running <= 1'b0;
		end
		else if (start)
		begin
			count   <= '0;
			running <= 1'b1;
		end
		else if (stop || (running && at_limit))
		begin
			// Halt on stop or after the expiry cycle
			running <= 1'b0;
		end
		else if (running)
		begin
			count <= count + 1'b1;
		end
	end

	// Single cycle, since the counter halts right after
	assign expired = running && at_limit;

endmodule

//--- hdl/range_matcher.sv
/* Combinational region lookup. Only the address bits above the granule are compared,
   and enabled regions must not overlap */
`timescale 1ns/1ps
`include "remap_macros.svh"

module range_matcher
(
	table_if.user tbl,
	lookup_if.matcher lkp
);

	// Width of the compared upper address field
	localparam int HIW = `REMAP_AW - `REMAP_GRAN_BITS;

	// Upper part of the request address
	logic [HIW-1:0] addr_hi;

	// Per region compare results
	logic [`REMAP_NREG-1:0] above_base;
	logic [`REMAP_NREG-1:0] below_last;
	logic [`REMAP_NREG-1:0] match;

	// Folded selection of the matching region
	logic [`REMAP_AW-1:0] sel_offset;
	logic [`REMAP_IDXW-1:0] sel_idx;

	assign addr_hi = lkp.addr[`REMAP_AW-1:`REMAP_GRAN_BITS];

	// ****************************************
	// Range compare per region
	// ****************************************

	for (genvar i = 0; i < `REMAP_NREG; i++)
	begin : g_region
		// Base and last are inclusive granule bounds
		assign above_base[i] = (addr_hi >= tbl.base_list[i][`REMAP_AW-1:`REMAP_GRAN_BITS]);
		assign below_last[i] = (addr_hi <= tbl.last_list[i][`REMAP_AW-1:`REMAP_GRAN_BITS]);
		// Disabled entries never match
		assign match[i] = tbl.enable[i] & above_base[i] & below_last[i];
	end

	// ****************************************
	// One-hot select and translation
	// ****************************************

	// OR fold over the match vector
	// Valid as long as at most one bit is set
	always_comb
	begin
		sel_offset = '0;
		sel_idx = '0;
		for (int i = 0; i < `REMAP_NREG; i++)
		begin
			if (match[i])
			begin
				sel_offset = sel_offset | tbl.offset_list[i];
				sel_idx = sel_idx | `REMAP_IDXW'(i);
			end
		end
	end

	assign lkp.hit = |match;
	assign lkp.hit_idx = sel_idx;

	// Offset applies to the full address, wrapping at 2^32
	assign lkp.xlat_addr = lkp.addr + sel_offset;

	// Overlapping enabled regions would merge offsets in the fold
	always_comb
	begin
		a_match_onehot: assert final ($onehot0(match))
		else $error("overlapping regions matched, vector %b", match);
	end

endmodule

//--- hdl/region_table.sv
/* Region registers, written one word per cfg_we strobe. A write lands at the strobe
   edge even while a request is in flight, so software must program while idle */
`timescale 1ns/1ps
`include "remap_macros.svh"

module region_table
(
	input logic clk,
	input logic rst_n,
	input logic cfg_we,
	input logic [`REMAP_IDXW-1:0] cfg_idx,
	input remap_pkg::cfg_field_e cfg_field,
	input remap_pkg::cfg_word_u cfg_wdata,
	table_if.owner tbl
);

	// ****************************************
	// Region storage
	// ****************************************

	// One word per region for each address field
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] base_q;
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] last_q;
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] offset_q;

	// Region enables, all off after reset
	logic [`REMAP_NREG-1:0] enable_q;

	// Field decode of one configuration strobe
	// CTRL takes the control view, the rest take the address view
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			base_q   <= '0;
			last_q   <= '0;
			offset_q <= '0;
			enable_q <= '0;
		end
		else if (cfg_we)
		begin
			case (cfg_field)
				remap_pkg::BASE:
				begin
					base_q[cfg_idx] <= cfg_wdata.addr;
				end
				remap_pkg::LAST:
				begin
					last_q[cfg_idx] <= cfg_wdata.addr;
				end
				remap_pkg::OFFSET:
				begin
					offset_q[cfg_idx] <= cfg_wdata.addr;
				end
				remap_pkg::CTRL:
				begin
					// Reserved control bits are dropped
					enable_q[cfg_idx] <= cfg_wdata.ctrl.enable;
				end
			endcase
		end
	end

	// ****************************************
	// Table view for the matcher
	// ****************************************

	assign tbl.base_list   = base_q;
	assign tbl.last_list   = last_q;
	assign tbl.offset_list = offset_q;
	assign tbl.enable      = enable_q;

	// An entry is enabled only once its bounds form a valid granule range
	a_cfg_enable_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(cfg_we && (cfg_field == remap_pkg::CTRL) && cfg_wdata.ctrl.enable)
		|-> (base_q[cfg_idx][`REMAP_AW-1:`REMAP_GRAN_BITS]
			<= last_q[cfg_idx][`REMAP_AW-1:`REMAP_GRAN_BITS])
	) else $error("region %0d enabled with base above last", cfg_idx);

endmodule

//--- hdl/remap_if.sv
/* Internal bundles of the remap unit. Both are purely combinational views,
   without clock or handshake */
`timescale 1ns/1ps
`include "remap_macros.svh"

// Region table contents, one word per region in each list
interface table_if;
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] base_list;
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] last_list;
	logic [`REMAP_NREG-1:0][`REMAP_AW-1:0] offset_list;
	logic [`REMAP_NREG-1:0] enable;

	// Table registers drive, matcher reads
	modport owner (output base_list, last_list, offset_list, enable);
	modport user (input base_list, last_list, offset_list, enable);
endinterface

// Address lookup between the request FSM and the matcher
interface lookup_if;
	logic [`REMAP_AW-1:0] addr;
	logic hit;
	logic [`REMAP_AW-1:0] xlat_addr;
	logic [`REMAP_IDXW-1:0] hit_idx;

	// FSM supplies the address and reads the result
	modport requester (output addr, input hit, xlat_addr, hit_idx);
	modport matcher (input addr, output hit, xlat_addr, hit_idx);
endinterface

//--- hdl/remap_pkg.sv
/* Shared types of the remap unit. The configuration word is read as an address
   for BASE, LAST and OFFSET writes and as a control word for CTRL writes */
`include "remap_macros.svh"

package remap_pkg;

	// ****************************************
	// Configuration write
	// ****************************************

	// Entry field targeted by a configuration strobe
	typedef enum logic [1:0]
	{
		BASE   = 2'd0,
		LAST   = 2'd1,
		OFFSET = 2'd2,
		CTRL   = 2'd3
	} cfg_field_e;

	// Control view of the word
	// Only bit 0 carries meaning for now
	typedef struct packed
	{
		logic [`REMAP_AW-2:0] rsvd;
		logic enable;
	} cfg_ctrl_t;

	// One configuration word, two decodings
	typedef union packed
	{
		logic [`REMAP_AW-1:0] addr;
		cfg_ctrl_t ctrl;
	} cfg_word_u;

	// ****************************************
	// Response
	// ****************************************

	typedef enum logic [1:0]
	{
		OK          = 2'd0,
		DECODE_ERR  = 2'd1,
		TIMEOUT_ERR = 2'd2
	} rsp_code_e;

endpackage

//--- hdl/remap_macros.svh
/* Sizing of the remap unit. Changing REMAP_NREG requires a matching REMAP_IDXW,
   and regions are always aligned to 2^REMAP_GRAN_BITS bytes */
`ifndef REMAP_MACROS_SVH
`define REMAP_MACROS_SVH

// Address and data word width
`define REMAP_AW 32

// Number of remap regions in the table
`define REMAP_NREG 4

// Width of a region index
`define REMAP_IDXW 2

// Low address bits ignored by the range compare
// 7 bits gives a 128 byte granule
`define REMAP_GRAN_BITS 7

// Cycles to wait for the downstream acknowledge
`define REMAP_TIMEOUT 64

`endif
